//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = iter_tb
FILELIST  = filelist.f
PASS_MSG  = sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/clock_gen.sv
module clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- bench/iter_tb.sv
module iter_tb
	import iter_pkg::*;
();

	localparam int WAIT_LIMIT   = 20;  // cycles from a start to its first address.
	localparam int STREAM_LIMIT = 200;
	localparam int DEPTH        = 1 << NS_INDEX_BITS;

	logic                       clk;
	logic                       reset;
	logic [OPCODE_BITS-1:0]     opcode;
	logic [FN_BITS-1:0]         fn;
	logic [IMMEDIATE_WIDTH-1:0] immediate;
	loop_id_t                   loop_id;
	logic                       in_nested_loop;
	logic [NUM_NS-1:0]          read_req;
	ns_addr_t [NUM_NS-1:0]      read_addr;
	logic [NUM_NS-1:0]          write_req_base;
	ns_addr_t [NUM_NS-1:0]      write_addr_base;
	word_t [NUM_NS-1:0]         write_data_base;
	logic [NUM_NS-1:0]          write_req_stride;
	ns_addr_t [NUM_NS-1:0]      write_addr_stride;
	word_t [NUM_NS-1:0]         write_data_stride;
	word_t [NUM_NS-1:0]         buffer_address;
	word_t [NUM_NS-1:0]         iterator_stride;
	logic [NUM_NS-1:0]          address_valid;
	logic                       loop_done;

	// model of the memories and of the loop setup.
	word_t base_mem_m   [NUM_NS][DEPTH];
	word_t stride_mem_m [NUM_NS][DEPTH];
	word_t base_m       [NUM_NS];
	word_t stride_m     [NUM_NS][NUM_MAX_LOOPS];
	iter_t iter_m       [NUM_MAX_LOOPS];

	int seed         = 22;
	int value_errors = 0;
	int timeouts     = 0;

	clock_gen clocks (.clk(clk), .reset(reset));

	iterator_memories dut (.*);

	// ================================================
	// compare
	// ================================================
	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ================================================
	// drive
	// ================================================
	task automatic drive_idle();
		opcode            <= '0;
		fn                <= '0;
		immediate         <= '0;
		loop_id           <= '0;
		read_req          <= '0;
		read_addr         <= '0;
		write_req_base    <= '0;
		write_addr_base   <= '0;
		write_data_base   <= '0;
		write_req_stride  <= '0;
		write_addr_stride <= '0;
		write_data_stride <= '0;
	endtask

	task automatic issue(input logic [FN_BITS-1:0] code, input loop_id_t id, input iter_t count);
		@(posedge clk);
		drive_idle();
		opcode    <= OP_LOOP;
		fn        <= code;
		loop_id   <= id;
		immediate <= {16'($random(seed)), count}; // upper half is noise.
	endtask

	task automatic write_words(input int ns, input ns_addr_t a);
		word_t b;
		word_t s;
		b = word_t'($random(seed));
		s = word_t'($random(seed));
		write_req_base[ns]    <= 1'b1;
		write_addr_base[ns]   <= a;
		write_data_base[ns]   <= b;
		write_req_stride[ns]  <= 1'b1;
		write_addr_stride[ns] <= a;
		write_data_stride[ns] <= s;
		base_mem_m[ns][a]   = b;
		stride_mem_m[ns][a] = s;
	endtask

	// the read was requested in the current cycle.
	task automatic check_read_data(input int ns, input ns_addr_t a, input word_t b, input word_t s);
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		check_word(buffer_address[ns], b, $sformatf("ns %0d base word %0d", ns, a));
		check_word(iterator_stride[ns], s, $sformatf("ns %0d stride word %0d", ns, a));
	endtask

	// ================================================
	// memory tests
	// ================================================
	task automatic fill_memories();
		for (int a = 0; a < DEPTH; a++) begin
			@(posedge clk);
			drive_idle();
			for (int ns = 0; ns < NUM_NS; ns++) begin
				write_words(ns, ns_addr_t'(a));
			end
		end
	endtask

	task automatic random_read_write(input int rounds);
		int       ns;
		ns_addr_t a;
		for (int r = 0; r < rounds; r++) begin
			ns = int'($unsigned($random(seed)) % NUM_NS);
			a  = ns_addr_t'($random(seed));
			@(posedge clk);
			drive_idle();
			write_words(ns, a);
			@(posedge clk);
			drive_idle();
			read_req[ns]  <= 1'b1;
			read_addr[ns] <= a;
			check_read_data(ns, a, base_mem_m[ns][a], stride_mem_m[ns][a]);
		end
	endtask

	task automatic same_cycle_read_write();
		word_t    old_b;
		word_t    old_s;
		ns_addr_t a;
		for (int ns = 0; ns < NUM_NS; ns++) begin
			a     = ns_addr_t'($random(seed));
			old_b = base_mem_m[ns][a];
			old_s = stride_mem_m[ns][a];
			@(posedge clk);
			drive_idle();
			write_words(ns, a);
			read_req[ns]  <= 1'b1;
			read_addr[ns] <= a;
			check_read_data(ns, a, old_b, old_s);
			@(posedge clk);
			read_req[ns]  <= 1'b1;
			read_addr[ns] <= a;
			check_read_data(ns, a, base_mem_m[ns][a], stride_mem_m[ns][a]);
		end
	endtask

	// ================================================
	// loop tests
	// ================================================
	task automatic setup_loop();
		ns_addr_t a;
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			iter_m[k] = iter_t'($unsigned($random(seed)) % 4);
			issue(FN_SET_ITER, loop_id_t'(k), iter_m[k]);
		end
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			issue(FN_SET_STRIDE, loop_id_t'(k), '0);
			for (int ns = 0; ns < NUM_NS; ns++) begin
				a = ns_addr_t'($random(seed));
				read_req[ns]    <= 1'b1;
				read_addr[ns]   <= a;
				stride_m[ns][k] = stride_mem_m[ns][a];
				if (k == 0) begin
					base_m[ns] = base_mem_m[ns][a];
				end
			end
		end
		@(posedge clk);
		drive_idle();
	endtask

	// odometer order, level 0 fastest.
	function automatic word_t expected_address(input int ns, input int idx);
		word_t a;
		int    rest;
		int    c;
		a    = base_m[ns];
		rest = idx;
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			c    = (iter_m[k] == '0) ? 1 : int'(iter_m[k]);
			a    = a + word_t'(rest % c) * stride_m[ns][k];
			rest = rest / c;
		end
		return a;
	endfunction

	task automatic run_loop();
		int total;
		int lat;
		int seen;
		total = 1;
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			total = total * ((iter_m[k] == '0) ? 1 : int'(iter_m[k]));
		end
		issue(FN_START, '0, '0);
		in_nested_loop <= 1'b1;
		@(posedge clk);
		drive_idle();
		lat = 1;
		@(negedge clk);
		while (address_valid == '0 && lat < WAIT_LIMIT) begin
			@(negedge clk);
			lat++;
		end
		if (address_valid == '0) begin
			timeouts++;
			$display("no address came within %0d cycles of a start", WAIT_LIMIT);
		end else begin
			check_word(word_t'(lat), word_t'(2), "cycles from start to first address");
			seen = 0;
			while (address_valid != '0 && seen < STREAM_LIMIT) begin
				for (int ns = 0; ns < NUM_NS; ns++) begin
					check_bit(address_valid[ns], 1'b1, $sformatf("ns %0d valid", ns));
					check_word(buffer_address[ns], expected_address(ns, seen),
						$sformatf("ns %0d address %0d", ns, seen));
				end
				check_bit(loop_done, logic'(seen == total - 1),
					$sformatf("loop_done at address %0d", seen));
				seen++;
				@(negedge clk);
			end
			if (seen >= STREAM_LIMIT) begin
				timeouts++;
				$display("address stream did not end after %0d addresses", STREAM_LIMIT);
			end
			check_word(word_t'(seen), word_t'(total), "number of addresses");
		end
		check_bit(loop_done, 1'b0, "loop_done after the run");
		// the last address wipes the loop setup.
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			iter_m[k] = '0;
			for (int ns = 0; ns < NUM_NS; ns++) begin
				base_m[ns]      = '0;
				stride_m[ns][k] = '0;
			end
		end
	endtask

	task automatic ignored_start();
		issue(FN_START, '0, '0);
		in_nested_loop <= 1'b0;
		@(posedge clk);
		drive_idle();
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_word(word_t'(address_valid), '0, "address_valid after an ignored start");
			check_bit(loop_done, 1'b0, "loop_done after an ignored start");
			@(posedge clk);
			in_nested_loop <= (c >= 3); // a late level must not revive it.
		end
	endtask

	// ================================================
	// main sequence
	// ================================================
	initial begin
		int guard;
		drive_idle();
		in_nested_loop <= 1'b0;
		guard = 0;
		while (reset !== 1'b0 && guard < 40) begin
			@(posedge clk);
			guard++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			$display("reset was never released");
		end
		@(negedge clk);
		check_word(word_t'(address_valid), '0, "address_valid after reset");
		check_bit(loop_done, 1'b0, "loop_done after reset");
		fill_memories();
		random_read_write(60);
		same_cycle_read_write();
		for (int r = 0; r < 4; r++) begin
			setup_loop();
			run_loop();
			run_loop(); // setup was cleared, one address at 0.
		end
		ignored_start();
		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
rtl/iter_pkg.sv
rtl/loop_instr_decode.sv
rtl/iterator_ram.sv
rtl/nested_loop_agu.sv
rtl/namespace_iterator.sv
rtl/iterator_memories.sv
bench/clock_gen.sv
bench/iter_tb.sv

//--- rtl/iter_pkg.sv
package iter_pkg;

	// ================================================
	// sizes
	// ================================================
	localparam int NUM_NS          = 6;   // namespaces.
	localparam int NS_INDEX_BITS   = 5;   // 32 words per memory.
	localparam int LOOP_ID_BITS    = 2;
	localparam int NUM_MAX_LOOPS   = 4;   // loop levels.

	localparam int OPCODE_BITS     = 4;
	localparam int FN_BITS         = 4;
	localparam int IMMEDIATE_WIDTH = 32;
	localparam int NUM_ITER_WIDTH  = 16;  // count comes from immediate[15:0].
	localparam int WORD_WIDTH      = 32;  // base, stride and address.

	// ================================================
	// instruction codes
	// ================================================
	localparam logic [OPCODE_BITS-1:0] OP_LOOP = 4'b0111;

	localparam logic [FN_BITS-1:0] FN_SET_STRIDE = 4'b0000; // level 0 also loads base.
	localparam logic [FN_BITS-1:0] FN_SET_ITER   = 4'b0001;
	localparam logic [FN_BITS-1:0] FN_START      = 4'b0010;

	// ================================================
	// types
	// ================================================
	typedef logic [WORD_WIDTH-1:0]     word_t;
	typedef logic [NS_INDEX_BITS-1:0]  ns_addr_t;
	typedef logic [LOOP_ID_BITS-1:0]   loop_id_t;
	typedef logic [NUM_ITER_WIDTH-1:0] iter_t;

endpackage

//--- rtl/iterator_memories.sv
module iterator_memories
	import iter_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [OPCODE_BITS-1:0]     opcode,
	input  logic [FN_BITS-1:0]         fn,
	input  logic [IMMEDIATE_WIDTH-1:0] immediate,
	input  loop_id_t                   loop_id,
	input  logic                       in_nested_loop,
	input  logic [NUM_NS-1:0]          read_req,
	input  ns_addr_t [NUM_NS-1:0]      read_addr,
	input  logic [NUM_NS-1:0]          write_req_base,
	input  ns_addr_t [NUM_NS-1:0]      write_addr_base,
	input  word_t [NUM_NS-1:0]         write_data_base,
	input  logic [NUM_NS-1:0]          write_req_stride,
	input  ns_addr_t [NUM_NS-1:0]      write_addr_stride,
	input  word_t [NUM_NS-1:0]         write_data_stride,
	output word_t [NUM_NS-1:0]         buffer_address,
	output word_t [NUM_NS-1:0]         iterator_stride,
	output logic [NUM_NS-1:0]          address_valid,
	output logic                       loop_done
);

	logic              set_iter;
	logic              set_stride;
	logic              start;
	loop_id_t          loop_id_now;
	loop_id_t          loop_id_d;
	logic [NUM_NS-1:0] ns_done;

	loop_instr_decode decode (
		.clk         (clk),
		.reset       (reset),
		.opcode      (opcode),
		.fn          (fn),
		.loop_id     (loop_id),
		.set_iter    (set_iter),
		.set_stride  (set_stride),
		.start       (start),
		.loop_id_now (loop_id_now),
		.loop_id_d   (loop_id_d)
	);

	// every namespace sees the same loop instructions.
	for (genvar g = 0; g < NUM_NS; g++) begin : g_ns
		namespace_iterator ns (
			.clk               (clk),
			.reset             (reset),
			.set_iter          (set_iter),
			.set_stride        (set_stride),
			.start             (start),
			.loop_id_now       (loop_id_now),
			.loop_id_d         (loop_id_d),
			.immediate         (immediate),
			.in_nested_loop    (in_nested_loop),
			.read_req          (read_req[g]),
			.read_addr         (read_addr[g]),
			.write_req_base    (write_req_base[g]),
			.write_addr_base   (write_addr_base[g]),
			.write_data_base   (write_data_base[g]),
			.write_req_stride  (write_req_stride[g]),
			.write_addr_stride (write_addr_stride[g]),
			.write_data_stride (write_data_stride[g]),
			.buffer_address    (buffer_address[g]),
			.iterator_stride   (iterator_stride[g]),
			.address_valid     (address_valid[g]),
			.loop_done         (ns_done[g])
		);
	end

	assign loop_done = |ns_done;

endmodule

//--- rtl/iterator_ram.sv
module iterator_ram
	import iter_pkg::*;
(
	input  logic     clk,
	input  logic     read_req,
	input  ns_addr_t read_addr,
	output word_t    read_data,
	input  logic     write_req,
	input  ns_addr_t write_addr,
	input  word_t    write_data
);

	localparam int DEPTH = 1 << NS_INDEX_BITS;

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (write_req) begin
			mem[write_addr] <= write_data;
		end
	end

	// same address read and write returns the old word.
	always_ff @(posedge clk) begin
		if (read_req) begin
			read_data <= mem[read_addr]; // held until the next request.
		end
	end

endmodule

//--- rtl/loop_instr_decode.sv
module loop_instr_decode
	import iter_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [OPCODE_BITS-1:0] opcode,
	input  logic [FN_BITS-1:0]     fn,
	input  loop_id_t               loop_id,
	output logic                   set_iter,
	output logic                   set_stride,
	output logic                   start,
	output loop_id_t               loop_id_now,
	output loop_id_t               loop_id_d
);

	logic is_loop;
	logic stride_hit;
	logic start_hit;

	assign is_loop    = (opcode == OP_LOOP);
	assign stride_hit = is_loop && (fn == FN_SET_STRIDE);
	assign start_hit  = is_loop && (fn == FN_START);

	// the count comes straight from the immediate, so no delay is needed.
	assign set_iter    = is_loop && (fn == FN_SET_ITER);
	assign loop_id_now = loop_id;

	// stride and base wait one cycle for the memory read data.
	always_ff @(posedge clk) begin
		if (reset) begin
			set_stride <= 1'b0;
			start      <= 1'b0;
			loop_id_d  <= '0;
		end else begin
			set_stride <= stride_hit;
			start      <= start_hit;
			loop_id_d  <= loop_id;
		end
	end

endmodule

//--- rtl/namespace_iterator.sv
module namespace_iterator
	import iter_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       set_iter,
	input  logic                       set_stride,
	input  logic                       start,
	input  loop_id_t                   loop_id_now,
	input  loop_id_t                   loop_id_d,
	input  logic [IMMEDIATE_WIDTH-1:0] immediate,
	input  logic                       in_nested_loop,
	input  logic                       read_req,
	input  ns_addr_t                   read_addr,
	input  logic                       write_req_base,
	input  ns_addr_t                   write_addr_base,
	input  word_t                      write_data_base,
	input  logic                       write_req_stride,
	input  ns_addr_t                   write_addr_stride,
	input  word_t                      write_data_stride,
	output word_t                      buffer_address,
	output word_t                      iterator_stride,
	output logic                       address_valid,
	output logic                       loop_done
);

	word_t                     base_rdata;
	word_t                     stride_rdata;
	word_t                     base_reg;
	word_t [NUM_MAX_LOOPS-1:0] stride_reg;
	iter_t [NUM_MAX_LOOPS-1:0] num_iter_reg;
	word_t                     agu_address;

	// ================================================
	// memories
	// ================================================
	iterator_ram base_mem (
		.clk        (clk),
		.read_req   (read_req),
		.read_addr  (read_addr),
		.read_data  (base_rdata),
		.write_req  (write_req_base),
		.write_addr (write_addr_base),
		.write_data (write_data_base)
	);

	iterator_ram stride_mem (
		.clk        (clk),
		.read_req   (read_req),
		.read_addr  (read_addr),
		.read_data  (stride_rdata),
		.write_req  (write_req_stride),
		.write_addr (write_addr_stride),
		.write_data (write_data_stride)
	);

	// ================================================
	// loop configuration
	// ================================================
	// done wipes the setup so every run needs a fresh one.
	always_ff @(posedge clk) begin
		if (reset || loop_done) begin
			base_reg     <= '0;
			stride_reg   <= '0;
			num_iter_reg <= '0;
		end else begin
			if (set_iter) begin
				num_iter_reg[loop_id_now] <= immediate[NUM_ITER_WIDTH-1:0];
			end
			if (set_stride) begin
				stride_reg[loop_id_d] <= stride_rdata;
				if (loop_id_d == '0) begin
					base_reg <= base_rdata; // only level 0 carries the base.
				end
			end
		end
	end

	nested_loop_agu agu (
		.clk           (clk),
		.reset         (reset),
		.enable        (in_nested_loop),
		.start         (start),
		.base          (base_reg),
		.stride        (stride_reg),
		.num_iter      (num_iter_reg),
		.address       (agu_address),
		.address_valid (address_valid),
		.loop_done     (loop_done)
	);

	assign buffer_address  = address_valid ? agu_address : base_rdata;
	assign iterator_stride = stride_rdata;

endmodule

//--- rtl/nested_loop_agu.sv
module nested_loop_agu
	import iter_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       enable,
	input  logic                       start,
	input  word_t                      base,
	input  word_t [NUM_MAX_LOOPS-1:0]  stride,
	input  iter_t [NUM_MAX_LOOPS-1:0]  num_iter,
	output word_t                      address,
	output logic                       address_valid,
	output logic                       loop_done
);

	logic                      busy;
	logic                      step;
	iter_t [NUM_MAX_LOOPS-1:0] count;
	word_t [NUM_MAX_LOOPS-1:0] offset;   // count[k] * stride[k] built by adding.
	logic  [NUM_MAX_LOOPS-1:0] at_last;
	logic  [NUM_MAX_LOOPS:0]   carry;    // carry[k] means level k steps this cycle.
	word_t                     offset_sum;

	assign step = busy && enable;

	// ================================================
	// odometer carry chain
	// ================================================
	assign carry[0] = 1'b1;

	for (genvar k = 0; k < NUM_MAX_LOOPS; k++) begin : g_level
		// a count of 0 behaves as 1.
		assign at_last[k] = (num_iter[k] <= iter_t'(1)) ?
			(count[k] == '0) :
			(count[k] == num_iter[k] - iter_t'(1));
		assign carry[k+1] = carry[k] && at_last[k];
	end

	always_comb begin
		offset_sum = '0;
		for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
			offset_sum = offset_sum + offset[k];
		end
	end

	assign address       = base + offset_sum; // wraps modulo 2^32.
	assign address_valid = step;
	assign loop_done     = step && carry[NUM_MAX_LOOPS];

	// ================================================
	// counters
	// ================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			count  <= '0;
			offset <= '0;
		end else if (!busy) begin
			if (start && enable) begin
				busy   <= 1'b1;
				count  <= '0;
				offset <= '0;
			end
		end else if (enable) begin
			if (carry[NUM_MAX_LOOPS]) begin
				busy <= 1'b0; // last address goes out this cycle.
			end
			for (int k = 0; k < NUM_MAX_LOOPS; k++) begin
				if (carry[k]) begin
					if (at_last[k]) begin
						count[k]  <= '0;
						offset[k] <= '0;
					end else begin
						count[k]  <= count[k] + iter_t'(1);
						offset[k] <= offset[k] + stride[k];
					end
				end
			end
		end
	end

	// ================================================
	// checks
	// ================================================
	// a setup change during a run would push a count out of range.
	for (genvar k = 0; k < NUM_MAX_LOOPS; k++) begin : g_check
		a_count_range: assert property (
			@(posedge clk) disable iff (reset)
			busy |-> (count[k] == '0 || count[k] < num_iter[k])
		) else $error("level %0d count outside its iteration range.", k);
	end

endmodule
